// ==== backend.sv ====
`timescale 1ns/1ps

module backend (
    input  logic clk,
    input  logic reset_i,
    input  logic inst_valid_i,
    input  pipeline_types::bus32_t inst_pc_i,
    input  pipeline_types::bus32_t inst_i,
    output logic [pipeline_types::PIPE_WIDTH-1:0] flush_o,
    output logic [pipeline_types::PIPE_WIDTH-1:0] pause_o,
    output pipeline_types::bus32_t new_pc_o,
    output logic ls_req_o,
    output logic ls_we_o,
    output pipeline_types::bus32_t ls_addr_o,
    output pipeline_types::bus32_t ls_wdata_o,
    input  logic ls_done_i,
    input  pipeline_types::bus32_t ls_rdata_i,
    output logic inst_valid_o,
    output pipeline_types::bus32_t debug_wb_pc_o,
    output pipeline_types::bus32_t debug_wb_inst_o,
    output logic debug_wb_rf_wen_o,
    output logic [4:0] debug_wb_rf_wnum_o,
    output pipeline_types::bus32_t debug_wb_rf_wdata_o
);
    import pipeline_types::*;

    opcode_t op;
    logic [4:0] rd;
    logic [4:0] rj;
    logic [4:0] rk;
    logic [4:0] rb_addr;
    bus32_t imm;
    bus32_t rf_a;
    bus32_t rf_b;
    bus32_t src_a;
    bus32_t src_b;
    bus32_t alu_res;
    logic uses_rk;
    logic writes_rd;
    logic is_mem;
    logic taken;
    logic exec_fire;
    logic mem_pending_q;

    assign op = inst_opcode(inst_i);
    assign rd = inst_rd(inst_i);
    assign rj = inst_rj(inst_i);
    assign rk = inst_rk(inst_i);
    assign imm = inst_imm(inst_i);

    assign uses_rk = op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR};
    assign writes_rd = uses_rk || (op == OP_ADDI) || (op == OP_LD_W);
    assign is_mem = op inside {OP_LD_W, OP_ST_W};
    assign rb_addr = uses_rk ? rk : rd;

    regfile u_regfile (
        .clk,
        .reset_i,
        .raddr_a_i(rj),
        .raddr_b_i(rb_addr),
        .rdata_a_o(rf_a),
        .rdata_b_o(rf_b),
        .we_i(debug_wb_rf_wen_o),
        .waddr_i(debug_wb_rf_wnum_o),
        .wdata_i(debug_wb_rf_wdata_o)
    );

    // the commit registers double as the writeback stage and feed forwarding.
    assign src_a = (debug_wb_rf_wen_o && (debug_wb_rf_wnum_o == rj)) ? debug_wb_rf_wdata_o : rf_a;
    assign src_b = (debug_wb_rf_wen_o && (debug_wb_rf_wnum_o == rb_addr)) ?
                   debug_wb_rf_wdata_o : rf_b;

    always_comb begin
        alu_res = src_a + imm;
        case (op)
            OP_ADD: alu_res = src_a + src_b;
            OP_SUB: alu_res = src_a - src_b;
            OP_AND: alu_res = src_a & src_b;
            OP_OR:  alu_res = src_a | src_b;
            OP_XOR: alu_res = src_a ^ src_b;
            default: ;
        endcase
    end

    assign taken = inst_valid_i && (((op == OP_BEQ) && (src_a == src_b)) ||
                                    ((op == OP_BNE) && (src_a != src_b)));
    assign new_pc_o = inst_pc_i + 32'd4 + {imm[29:0], 2'b00};

    // the branch itself retires, so only the stages behind it are flushed.
    always_comb begin
        flush_o = '0;
        flush_o[STAGE_FETCH] = taken;
        flush_o[STAGE_ICACHE] = taken;
    end

    assign pause_o = {PIPE_WIDTH{inst_valid_i && is_mem && !ls_done_i}};
    assign exec_fire = inst_valid_i && !pause_o[STAGE_EXEC];

    assign ls_req_o = inst_valid_i && is_mem && !mem_pending_q;
    assign ls_we_o = (op == OP_ST_W);
    assign ls_addr_o = alu_res;
    assign ls_wdata_o = src_b;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            inst_valid_o <= 1'b0;
            debug_wb_rf_wen_o <= 1'b0;
            mem_pending_q <= 1'b0;
        end else begin
            inst_valid_o <= exec_fire;
            debug_wb_rf_wen_o <= exec_fire && writes_rd && (rd != 5'd0);
            if (ls_req_o) begin
                mem_pending_q <= 1'b1;
            end else if (ls_done_i) begin
                mem_pending_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (exec_fire) begin
            debug_wb_pc_o <= inst_pc_i;
            debug_wb_inst_o <= inst_i;
            debug_wb_rf_wnum_o <= rd;
            debug_wb_rf_wdata_o <= (op == OP_LD_W) ? ls_rdata_i : alu_res;
        end
    end
endmodule

// ==== cpu.f ====
pipeline_types.sv
regfile.sv
frontend.sv
icache.sv
lsu.sv
backend.sv
cpu.sv
tb_mem.sv
tb_cpu.sv

// ==== cpu.sv ====
`timescale 1ns/1ps

module cpu #(
    parameter int ICACHE_LINES = 8,
    parameter pipeline_types::bus32_t RESET_PC = 32'h0
) (
    input  logic clk,
    input  logic reset_i,

    input  logic icache_ret_valid_i,
    input  pipeline_types::bus256_t icache_ret_data_i,
    output logic icache_rd_req_o,
    output pipeline_types::bus32_t icache_rd_addr_o,

    // ducache suffixes name the data cache side, so _i ports leave the core.
    output logic ducache_ren_i,
    output pipeline_types::bus32_t ducache_araddr_i,
    input  logic ducache_rvalid_o,
    input  pipeline_types::bus32_t ducache_rdata_o,
    output logic ducache_wen_i,
    output pipeline_types::bus32_t ducache_wdata_i,
    output pipeline_types::bus32_t ducache_awaddr_i,
    output logic [3:0] ducache_strb,
    input  logic ducache_bvalid_o,

    output logic inst_valid_o,
    output pipeline_types::bus32_t debug_wb_pc_o,
    output pipeline_types::bus32_t debug_wb_inst_o,
    output logic debug_wb_rf_wen_o,
    output logic [4:0] debug_wb_rf_wnum_o,
    output pipeline_types::bus32_t debug_wb_rf_wdata_o
);
    import pipeline_types::*;

    logic [PIPE_WIDTH-1:0] flush;
    logic [PIPE_WIDTH-1:0] pause;
    bus32_t fetch_pc;
    bus32_t new_pc;
    logic stall;
    logic inst_valid;
    bus32_t inst_pc;
    bus32_t inst;
    logic ls_req;
    logic ls_we;
    bus32_t ls_addr;
    bus32_t ls_wdata;
    logic ls_done;
    bus32_t ls_rdata;

    frontend #(.RESET_PC(RESET_PC)) u_frontend (
        .clk, .reset_i,
        .pause_i(pause[STAGE_FETCH]), .flush_i(flush[STAGE_FETCH]),
        .new_pc_i(new_pc), .stall_i(stall), .fetch_pc_o(fetch_pc)
    );

    icache #(.ICACHE_LINES(ICACHE_LINES)) u_icache (
        .clk, .reset_i,
        .pause_i(pause[STAGE_ICACHE]), .flush_i(flush[STAGE_ICACHE]),
        .fetch_pc_i(fetch_pc), .stall_o(stall),
        .inst_valid_o(inst_valid), .inst_pc_o(inst_pc), .inst_o(inst),
        .rd_req_o(icache_rd_req_o), .rd_addr_o(icache_rd_addr_o),
        .ret_valid_i(icache_ret_valid_i), .ret_data_i(icache_ret_data_i)
    );

    backend u_backend (
        .clk, .reset_i,
        .inst_valid_i(inst_valid), .inst_pc_i(inst_pc), .inst_i(inst),
        .flush_o(flush), .pause_o(pause), .new_pc_o(new_pc),
        .ls_req_o(ls_req), .ls_we_o(ls_we), .ls_addr_o(ls_addr), .ls_wdata_o(ls_wdata),
        .ls_done_i(ls_done), .ls_rdata_i(ls_rdata),
        .inst_valid_o, .debug_wb_pc_o, .debug_wb_inst_o,
        .debug_wb_rf_wen_o, .debug_wb_rf_wnum_o, .debug_wb_rf_wdata_o
    );

    lsu u_lsu (
        .clk, .reset_i,
        .ls_req_i(ls_req), .ls_we_i(ls_we), .ls_addr_i(ls_addr), .ls_wdata_i(ls_wdata),
        .ls_done_o(ls_done), .ls_rdata_o(ls_rdata),
        .ducache_ren_i, .ducache_araddr_i, .ducache_rvalid_o, .ducache_rdata_o,
        .ducache_wen_i, .ducache_wdata_i, .ducache_awaddr_i, .ducache_strb,
        .ducache_bvalid_o
    );
endmodule

// ==== frontend.sv ====
`timescale 1ns/1ps

module frontend #(
    parameter pipeline_types::bus32_t RESET_PC = 32'h0
) (
    input  logic clk,
    input  logic reset_i,
    input  logic pause_i,
    input  logic flush_i,
    input  pipeline_types::bus32_t new_pc_i,
    input  logic stall_i,
    output pipeline_types::bus32_t fetch_pc_o
);
    import pipeline_types::*;

    bus32_t pc_q;
    bus32_t pc_next;

    // a resolved branch wins over both a pause and an icache stall.
    always_comb begin
        if (flush_i) begin
            pc_next = new_pc_i;
        end else if (pause_i || stall_i) begin
            pc_next = pc_q;
        end else begin
            pc_next = pc_q + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    assign fetch_pc_o = pc_q;
endmodule

// ==== icache.sv ====
`timescale 1ns/1ps

module icache #(
    parameter int ICACHE_LINES = 8
) (
    input  logic clk,
    input  logic reset_i,
    input  logic pause_i,
    input  logic flush_i,
    input  pipeline_types::bus32_t fetch_pc_i,
    output logic stall_o,
    output logic inst_valid_o,
    output pipeline_types::bus32_t inst_pc_o,
    output pipeline_types::bus32_t inst_o,
    output logic rd_req_o,
    output pipeline_types::bus32_t rd_addr_o,
    input  logic ret_valid_i,
    input  pipeline_types::bus256_t ret_data_i
);
    import pipeline_types::*;

    localparam int IDX_W = $clog2(ICACHE_LINES);
    localparam int TAG_W = 27 - IDX_W;

    // the line is filled on the return cycle of the request state.
    typedef enum logic {ST_IDLE, ST_REQ} state_t;

    state_t state_q;
    logic drop_q;
    logic [ICACHE_LINES-1:0] valid_q;
    logic [TAG_W-1:0] tag_q [ICACHE_LINES];
    bus256_t line_q [ICACHE_LINES];
    bus32_t miss_pc_q;

    logic [IDX_W-1:0] pc_idx;
    logic [IDX_W-1:0] fill_idx;
    logic [TAG_W-1:0] pc_tag;
    logic hit;
    logic lookup_en;
    logic miss_start;
    logic fill;
    logic deliver;

    assign pc_idx = fetch_pc_i[5 +: IDX_W];
    assign pc_tag = fetch_pc_i[31 -: TAG_W];
    assign fill_idx = miss_pc_q[5 +: IDX_W];
    assign hit = valid_q[pc_idx] && (tag_q[pc_idx] == pc_tag);

    assign lookup_en = (state_q == ST_IDLE) && !flush_i && !pause_i;
    assign miss_start = lookup_en && !hit;
    assign fill = (state_q == ST_REQ) && ret_valid_i;
    // a line fetched for a flushed path is kept, but its word is not passed on.
    assign deliver = fill && !drop_q && !flush_i && !pause_i;

    assign stall_o = (state_q == ST_IDLE) ? !hit : !deliver;
    assign rd_req_o = (state_q == ST_REQ);
    assign rd_addr_o = {miss_pc_q[31:5], 5'b0};

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= ST_IDLE;
            drop_q <= 1'b0;
            valid_q <= '0;
            inst_valid_o <= 1'b0;
        end else begin
            if (miss_start) begin
                state_q <= ST_REQ;
                drop_q <= 1'b0;
            end else if (fill) begin
                state_q <= ST_IDLE;
                valid_q[fill_idx] <= 1'b1;
            end else if ((state_q == ST_REQ) && flush_i) begin
                drop_q <= 1'b1;
            end

            if (flush_i) begin
                inst_valid_o <= 1'b0;
            end else if (lookup_en) begin
                inst_valid_o <= hit;
            end else if (deliver) begin
                inst_valid_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (miss_start) begin
            miss_pc_q <= fetch_pc_i;
        end
        if (fill) begin
            tag_q[fill_idx] <= miss_pc_q[31 -: TAG_W];
            line_q[fill_idx] <= ret_data_i;
        end
        if (lookup_en && hit) begin
            inst_o <= line_word(line_q[pc_idx], fetch_pc_i[4:2]);
            inst_pc_o <= fetch_pc_i;
        end else if (deliver) begin
            inst_o <= line_word(ret_data_i, miss_pc_q[4:2]);
            inst_pc_o <= miss_pc_q;
        end
    end
endmodule

// ==== lsu.sv ====
`timescale 1ns/1ps

module lsu (
    input  logic clk,
    input  logic reset_i,
    input  logic ls_req_i,
    input  logic ls_we_i,
    input  pipeline_types::bus32_t ls_addr_i,
    input  pipeline_types::bus32_t ls_wdata_i,
    output logic ls_done_o,
    output pipeline_types::bus32_t ls_rdata_o,
    output logic ducache_ren_i,
    output pipeline_types::bus32_t ducache_araddr_i,
    input  logic ducache_rvalid_o,
    input  pipeline_types::bus32_t ducache_rdata_o,
    output logic ducache_wen_i,
    output pipeline_types::bus32_t ducache_wdata_i,
    output pipeline_types::bus32_t ducache_awaddr_i,
    output logic [3:0] ducache_strb,
    input  logic ducache_bvalid_o
);
    import pipeline_types::*;

    typedef enum logic [1:0] {ST_IDLE, ST_READ, ST_WRITE, ST_DONE} state_t;

    state_t state_q;
    bus32_t addr_q;
    bus32_t wdata_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE:  if (ls_req_i) state_q <= ls_we_i ? ST_WRITE : ST_READ;
                ST_READ:  if (ducache_rvalid_o) state_q <= ST_DONE;
                ST_WRITE: if (ducache_bvalid_o) state_q <= ST_DONE;
                default:  state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state_q == ST_IDLE) && ls_req_i) begin
            addr_q <= ls_addr_i;
            wdata_q <= ls_wdata_i;
        end
        if ((state_q == ST_READ) && ducache_rvalid_o) begin
            ls_rdata_o <= ducache_rdata_o;
        end
    end

    // request levels stay up until the matching response comes back.
    assign ducache_ren_i = (state_q == ST_READ);
    assign ducache_wen_i = (state_q == ST_WRITE);
    assign ducache_araddr_i = addr_q;
    assign ducache_awaddr_i = addr_q;
    assign ducache_wdata_i = wdata_q;
    assign ducache_strb = 4'b1111;
    assign ls_done_o = (state_q == ST_DONE);
endmodule

// ==== pipeline_types.sv ====
package pipeline_types;

    typedef logic [31:0] bus32_t;

    // word k of a line sits in bits 32k+31 down to 32k.
    typedef logic [255:0] bus256_t;

    localparam int PIPE_WIDTH = 3;
    localparam int STAGE_FETCH = 0;
    localparam int STAGE_ICACHE = 1;
    localparam int STAGE_EXEC = 2;

    // any opcode outside this set retires as a no-op without a register write.
    typedef enum logic [5:0] {
        OP_ADD  = 6'h01,
        OP_SUB  = 6'h02,
        OP_AND  = 6'h03,
        OP_OR   = 6'h04,
        OP_XOR  = 6'h05,
        OP_ADDI = 6'h06,
        OP_LD_W = 6'h07,
        OP_ST_W = 6'h08,
        OP_BEQ  = 6'h09,
        OP_BNE  = 6'h0a
    } opcode_t;

    function automatic opcode_t inst_opcode(input bus32_t inst);
        return opcode_t'(inst[31:26]);
    endfunction

    function automatic logic [4:0] inst_rd(input bus32_t inst);
        return inst[25:21];
    endfunction

    function automatic logic [4:0] inst_rj(input bus32_t inst);
        return inst[20:16];
    endfunction

    // only the register ops read rk; st_w, beq and bne take rd as second source.
    function automatic logic [4:0] inst_rk(input bus32_t inst);
        return inst[15:11];
    endfunction

    function automatic bus32_t inst_imm(input bus32_t inst);
        return {{16{inst[15]}}, inst[15:0]};
    endfunction

    function automatic bus32_t line_word(input bus256_t line, input logic [2:0] sel);
        return line[32*sel +: 32];
    endfunction

endpackage

// ==== regfile.sv ====
`timescale 1ns/1ps

module regfile (
    input  logic clk,
    input  logic reset_i,
    input  logic [4:0] raddr_a_i,
    input  logic [4:0] raddr_b_i,
    output pipeline_types::bus32_t rdata_a_o,
    output pipeline_types::bus32_t rdata_b_o,
    input  logic we_i,
    input  logic [4:0] waddr_i,
    input  pipeline_types::bus32_t wdata_i
);
    import pipeline_types::*;

    bus32_t regs_q [32];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && (waddr_i != 5'd0)) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // r0 is never written, so it always reads back as zero.
    assign rdata_a_o = regs_q[raddr_a_i];
    assign rdata_b_o = regs_q[raddr_b_i];
endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and searches the log for the pass line.
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module tb_cpu -f cpu.f -o tb_cpu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_cpu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

grep -qx "Result: PASSED" "$LOG"
exit $?

// ==== tb_cpu.sv ====
`timescale 1ns/1ps

module tb_cpu;
    import pipeline_types::*;

    localparam int NUM_COMMITS = 2000;
    localparam int CYCLES_PER_COMMIT = 40;
    localparam int RESET_CYCLES = 16;

    logic clk;
    logic reset_i;
    logic icache_ret_valid_i;
    bus256_t icache_ret_data_i;
    logic icache_rd_req_o;
    bus32_t icache_rd_addr_o;
    logic ducache_ren_i;
    bus32_t ducache_araddr_i;
    logic ducache_rvalid_o;
    bus32_t ducache_rdata_o;
    logic ducache_wen_i;
    bus32_t ducache_wdata_i;
    bus32_t ducache_awaddr_i;
    logic [3:0] ducache_strb;
    logic ducache_bvalid_o;
    logic inst_valid_o;
    bus32_t debug_wb_pc_o;
    bus32_t debug_wb_inst_o;
    logic debug_wb_rf_wen_o;
    logic [4:0] debug_wb_rf_wnum_o;
    bus32_t debug_wb_rf_wdata_o;

    integer seed = 32'h49e8;
    bus32_t model_regs [32];
    bus32_t model_dmem [256];
    bus32_t model_pc;
    int commit_count;
    logic quiet_window;

    cpu #(.ICACHE_LINES(8), .RESET_PC(32'h0)) dut (.*);

    tb_mem u_mem (
        .clk, .reset_i,
        .rd_req_i(icache_rd_req_o), .rd_addr_i(icache_rd_addr_o),
        .ret_valid_o(icache_ret_valid_i), .ret_data_o(icache_ret_data_i),
        .ren_i(ducache_ren_i), .araddr_i(ducache_araddr_i),
        .rvalid_o(ducache_rvalid_o), .rdata_o(ducache_rdata_o),
        .wen_i(ducache_wen_i), .awaddr_i(ducache_awaddr_i), .wdata_i(ducache_wdata_i),
        .strb_i(ducache_strb), .bvalid_o(ducache_bvalid_o)
    );

    always #2 clk = ~clk;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input bus32_t got, input bus32_t exp);
        assert (got == exp) else begin
            report_failure($sformatf("mismatch %s: got %08h, expected %08h (pc %08h)",
                                     name, got, exp, model_pc));
        end
    endtask

    task automatic check_quiet();
        assert (!icache_rd_req_o && !ducache_ren_i && !ducache_wen_i && !inst_valid_o) else begin
            report_failure("a request or commit output was active during or right after reset");
        end
    endtask

    // registers stay within r0 to r7 so that dependent neighbours are common.
    function automatic bus32_t random_inst();
        int sel;
        logic [4:0] rd;
        logic [4:0] rj;
        logic [4:0] rk;
        logic [15:0] imm;
        logic [15:0] off;
        sel = $unsigned($random(seed)) % 13;
        rd = 5'($unsigned($random(seed)) % 8);
        rj = 5'($unsigned($random(seed)) % 8);
        rk = 5'($unsigned($random(seed)) % 8);
        imm = 16'($random(seed));
        off = 16'($unsigned($random(seed)) % 16) - 16'd8;
        // an offset of minus one would branch to itself.
        if (off == 16'hffff) off = 16'd3;
        case (sel)
            0: return {OP_ADD, rd, rj, rk, 11'd0};
            1: return {OP_SUB, rd, rj, rk, 11'd0};
            2: return {OP_AND, rd, rj, rk, 11'd0};
            3: return {OP_OR, rd, rj, rk, 11'd0};
            4: return {OP_XOR, rd, rj, rk, 11'd0};
            5, 6: return {OP_ADDI, rd, rj, imm};
            7, 8: return {OP_LD_W, rd, rj, 9'd0, imm[4:0], 2'b00};
            9, 10: return {OP_ST_W, rd, rj, 9'd0, imm[4:0], 2'b00};
            11: return {OP_BEQ, rd, rj, off};
            default: return {OP_BNE, rd, rj, off};
        endcase
    endfunction

    // executes the instruction at the model pc and compares it with the commit.
    task automatic step_model();
        bus32_t inst;
        bus32_t a;
        bus32_t res;
        bus32_t next_pc;
        logic [4:0] rd;
        logic writes;
        inst = u_mem.imem[model_pc[9:2]];
        rd = inst_rd(inst);
        a = model_regs[inst_rj(inst)];
        res = a + inst_imm(inst);
        next_pc = model_pc + 32'd4;
        writes = 1'b1;
        case (inst_opcode(inst))
            OP_ADD: res = a + model_regs[inst_rk(inst)];
            OP_SUB: res = a - model_regs[inst_rk(inst)];
            OP_AND: res = a & model_regs[inst_rk(inst)];
            OP_OR:  res = a | model_regs[inst_rk(inst)];
            OP_XOR: res = a ^ model_regs[inst_rk(inst)];
            OP_ADDI: ;
            OP_LD_W: res = model_dmem[res[9:2]];
            OP_ST_W: begin
                model_dmem[res[9:2]] = model_regs[rd];
                writes = 1'b0;
            end
            OP_BEQ, OP_BNE: begin
                writes = 1'b0;
                if ((a == model_regs[rd]) == (inst_opcode(inst) == OP_BEQ))
                    next_pc = model_pc + 32'd4 + (inst_imm(inst) << 2);
            end
            default: writes = 1'b0;
        endcase
        check_value("debug_wb_pc_o", debug_wb_pc_o, model_pc);
        check_value("debug_wb_inst_o", debug_wb_inst_o, inst);
        check_value("debug_wb_rf_wen_o", 32'(debug_wb_rf_wen_o), 32'(writes && (rd != 5'd0)));
        if (writes && (rd != 5'd0)) begin
            check_value("debug_wb_rf_wnum_o", 32'(debug_wb_rf_wnum_o), 32'(rd));
            check_value("debug_wb_rf_wdata_o", debug_wb_rf_wdata_o, res);
            model_regs[rd] = res;
        end
        model_pc = next_pc;
    endtask

    always @(negedge clk) begin
        if (reset_i || quiet_window) begin
            check_quiet();
        end else if (inst_valid_o) begin
            step_model();
            commit_count = commit_count + 1;
        end
        quiet_window = reset_i;
    end

    initial begin
        clk = 1'b0;
        reset_i = 1'b1;
        quiet_window = 1'b0;
        commit_count = 0;
        model_pc = 32'h0;
        for (int r = 0; r < 32; r++) model_regs[r] = '0;
        for (int a = 0; a < 256; a++) begin
            u_mem.imem[a] = random_inst();
            model_dmem[a] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset_i = 1'b0;
        while (commit_count < NUM_COMMITS) @(posedge clk);
        $display("Result: PASSED");
        $finish;
    end

    initial begin
        repeat (NUM_COMMITS * CYCLES_PER_COMMIT + RESET_CYCLES) @(posedge clk);
        report_failure("timeout: the CPU did not retire enough instructions in time");
    end
endmodule

// ==== tb_mem.sv ====
`timescale 1ns/1ps

module tb_mem (
    input  logic clk,
    input  logic reset_i,
    input  logic rd_req_i,
    input  pipeline_types::bus32_t rd_addr_i,
    output logic ret_valid_o,
    output pipeline_types::bus256_t ret_data_o,
    input  logic ren_i,
    input  pipeline_types::bus32_t araddr_i,
    output logic rvalid_o,
    output pipeline_types::bus32_t rdata_o,
    input  logic wen_i,
    input  pipeline_types::bus32_t awaddr_i,
    input  pipeline_types::bus32_t wdata_i,
    input  logic [3:0] strb_i,
    output logic bvalid_o
);
    import pipeline_types::*;

    bus32_t imem [256];
    bus32_t dmem [256];
    integer seed = 32'h49e8;
    int i_wait;
    int d_wait;

    function automatic int pick_delay();
        return 1 + ($unsigned($random(seed)) % 6);
    endfunction

    initial begin
        ret_valid_o = 1'b0;
        ret_data_o = '0;
        rvalid_o = 1'b0;
        rdata_o = '0;
        bvalid_o = 1'b0;
        i_wait = 0;
        d_wait = 0;
        for (int a = 0; a < 256; a++) dmem[a] = '0;
    end

    // a wait count of zero means that no request is being served.
    always @(posedge clk) begin
        #1;
        ret_valid_o = 1'b0;
        rvalid_o = 1'b0;
        bvalid_o = 1'b0;
        if (reset_i) begin
            i_wait = 0;
            d_wait = 0;
        end else begin
            if (i_wait != 0) begin
                i_wait = i_wait - 1;
                if (i_wait == 0) begin
                    ret_valid_o = 1'b1;
                    for (int k = 0; k < 8; k++) begin
                        ret_data_o[32*k +: 32] = imem[{rd_addr_i[9:5], k[2:0]}];
                    end
                end
            end else if (rd_req_i) begin
                i_wait = pick_delay();
            end
            if (d_wait != 0) begin
                d_wait = d_wait - 1;
                if ((d_wait == 0) && ren_i) begin
                    rvalid_o = 1'b1;
                    rdata_o = dmem[araddr_i[9:2]];
                end else if (d_wait == 0) begin
                    bvalid_o = 1'b1;
                    for (int b = 0; b < 4; b++) begin
                        if (strb_i[b])
                            dmem[awaddr_i[9:2]][8*b +: 8] = wdata_i[8*b +: 8];
                    end
                end
            end else if (ren_i || wen_i) begin
                d_wait = pick_delay();
            end
        end
    end
endmodule
